//--- filelist.f
+incdir+verif
src/exec_pkg.sv
src/exec_alu.sv
src/branch_target_unit.sv
src/branch_resolve.sv
src/exec_stage.sv
verif/exec_stage_tb.sv

//--- Makefile
# Verilator build for the execute stage

TOP := exec_stage_tb
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module exec_stage
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o sim_$(TOP)
	-./obj_dir/sim_$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

//--- verif/exec_model.svh
`ifndef exec_model_svh
`define exec_model_svh

////////////////////
// reference rules
////////////////////

// operand b as named by src_b
function automatic word_t pick_operand_b(input exec_req_t req);
   word_t val;
   val = '0;
   if (req.src_b == src_b_reg)
      val = req.b;
   else if (req.src_b == src_b_imm)
      val = req.imm;
   else if (req.src_b == src_b_one)
      val = word_t'(1);
   return val;
endfunction

// one alu operation on operand 1 (x) and operand 2 (y)
function automatic word_t apply_alu_op(input alu_op_t op, input word_t x, input word_t y);
   word_t val;
   val = '0;
   case (op)
      alu_add: val = x + y;
      alu_sub: val = x + ~y + word_t'(1);
      alu_and: val = x & y;
      alu_or:  val = x | y;
      alu_xor: val = x ^ y;
      alu_not: val = ~x;
      // shifts by one with the sign bit copied on the right shift
      alu_shl: val = {x[word_width-2:0], 1'b0};
      alu_sra: val = {x[word_width-1], x[word_width-1:1]};
      alu_bne: val = word_t'(x != y);
      alu_beq: val = word_t'(x == y);
      // sign bit clear and not zero
      alu_bgz: val = word_t'(!x[word_width-1] && (x != '0));
      alu_blz: val = word_t'(x[word_width-1]);
      default: val = '0;
   endcase
   return val;
endfunction

// full response expected for one request
function automatic exec_rsp_t expected_rsp(input exec_req_t req);
   exec_rsp_t rsp;
   word_t     opnd_b;
   word_t     next_pc;
   opnd_b          = pick_operand_b(req);
   rsp.tag         = req.tag;
   rsp.is_branch   = req.is_branch;
   rsp.result      = req.swap ? apply_alu_op(req.alu_op, opnd_b, req.a)
                              : apply_alu_op(req.alu_op, req.a, opnd_b);
   next_pc         = req.pc + word_t'(1);
   rsp.taken       = req.is_branch && (rsp.result != '0);
   // target is relative to the next instruction
   rsp.resolved_pc = rsp.taken ? next_pc + req.imm : next_pc;
   rsp.miss        = req.is_branch && (rsp.resolved_pc != req.pred_npc);
   return rsp;
endfunction

`endif

//--- verif/exec_stage_tb.sv
`timescale 1ns/100ps
`default_nettype none

module exec_stage_tb;
   import exec_pkg::*;

   `include "exec_model.svh"

   logic      clk = 1'b0;
   logic      reset_n;
   logic      i_valid;
   logic      o_ready;
   exec_req_t i_req;
   logic      o_valid;
   logic      i_ready = 1'b1;
   exec_rsp_t o_rsp;
   word_t     o_num_branch;
   word_t     o_num_branch_miss;

   // expected responses kept in acceptance order
   exec_rsp_t exp_q[$];
   int        rsp_idx = 0;
   word_t     seen_branch = '0;
   word_t     seen_miss = '0;

   // one error count per checking process
   int chk_errors = 0;
   int cnt_errors = 0;
   int rst_errors = 0;
   int stable_errors = 0;
   int lat_errors = 0;

   string test_name = "reset";
   logic  random_ready = 1'b0;
   logic  lat_check = 1'b0;
   logic  timed_out = 1'b0;
   tag_t  next_tag = '0;
   int    passed = 0;
   int    failed = 0;
   int    errors_at_start = 0;

   exec_stage i_dut (
      .clk               (clk),
      .reset_n           (reset_n),
      .i_valid           (i_valid),
      .o_ready           (o_ready),
      .i_req             (i_req),
      .o_valid           (o_valid),
      .i_ready           (i_ready),
      .o_rsp             (o_rsp),
      .o_num_branch      (o_num_branch),
      .o_num_branch_miss (o_num_branch_miss)
   );

   // 100 ns period
   always #50 clk = ~clk;

   // sink with random stalls or always ready
   always @(negedge clk) begin
      if (random_ready)
         i_ready = 1'($urandom);
      else
         i_ready = 1'b1;
   end

   ////////////////////
   // checks
   ////////////////////

   // each leaving item against the oldest pending one
   always @(posedge clk) begin
      if (reset_n && o_valid && i_ready) begin
         if (rsp_idx >= exp_q.size()) begin
            $display("response with tag %h left while no item was pending", o_rsp.tag);
            chk_errors++;
         end
         else begin
            rsp_check: assert (o_rsp == exp_q[rsp_idx]) else begin
               $display("error %s: expected %h actual %h", test_name, exp_q[rsp_idx], o_rsp);
               chk_errors++;
            end
            if (exp_q[rsp_idx].is_branch)
               seen_branch = seen_branch + word_t'(1);
            if (exp_q[rsp_idx].miss)
               seen_miss = seen_miss + word_t'(1);
            rsp_idx++;
         end
      end
   end

   // idle outputs during and right after reset
   reset_state: assert property (@(posedge clk) !reset_n |=>
      (!o_valid && o_ready && o_num_branch == '0 && o_num_branch_miss == '0))
      else begin
         $display("outputs were not in their reset state in %s", test_name);
         rst_errors++;
      end

   // stalled output holds
   stall_hold: assert property (@(posedge clk) disable iff (!reset_n)
      (o_valid && !i_ready) |=> (o_valid && $stable(o_rsp)))
      else begin
         $display("output changed while stalled in %s", test_name);
         stable_errors++;
      end

   // accepted on edge k and at the output on edge k+2
   fixed_latency: assert property (@(posedge clk) disable iff (!reset_n)
      (lat_check && $past(i_valid && o_ready, 2)) |->
      (o_valid && o_rsp.tag == $past(i_req.tag, 2)))
      else begin
         $display("item was not at the output two edges after acceptance in %s", test_name);
         lat_errors++;
      end

   // no stall while the sink is always ready
   ready_high: assert property (@(posedge clk) disable iff (!reset_n) lat_check |-> o_ready)
      else begin
         $display("input ready dropped with the sink always ready in %s", test_name);
         lat_errors++;
      end

   ////////////////////
   // helpers
   ////////////////////

   function automatic int total_errors();
      return chk_errors + cnt_errors + rst_errors + stable_errors + lat_errors;
   endfunction

   task automatic finish_run();
      $display("tests passed %0d failed %0d", passed, failed);
      if (failed == 0 && total_errors() == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   endtask

   // main sequence idles until the run ends
   task automatic stop_on_timeout(input string what);
      $display("timeout in %s: %s", test_name, what);
      failed++;
      timed_out = 1'b1;
      forever @(posedge clk);
   endtask

   // mode changes land after a rising edge clear of the sink
   task automatic begin_test(input string name, input logic rand_ready, input logic latency);
      @(posedge clk);
      test_name       = name;
      random_ready    = rand_ready;
      lat_check       = latency;
      errors_at_start = total_errors();
   endtask

   task automatic end_test();
      if (total_errors() == errors_at_start) begin
         passed++;
         $display("test %s: pass", test_name);
      end
      else begin
         failed++;
         $display("test %s: fail with %0d errors", test_name, total_errors() - errors_at_start);
      end
   endtask

   // drive on the falling edge and hold until accepted
   task automatic send(input exec_req_t req);
      int   waited;
      logic accepted;
      accepted = 1'b0;
      req.tag  = next_tag;
      @(negedge clk);
      i_valid = 1'b1;
      i_req   = req;
      for (waited = 0; waited < 200 && !accepted; waited++) begin
         @(posedge clk);
         accepted = o_ready;
      end
      if (!accepted)
         stop_on_timeout("request was not accepted within 200 cycles");
      exp_q.push_back(expected_rsp(req));
      next_tag++;
   endtask

   task automatic drain();
      int waited;
      @(negedge clk);
      i_valid = 1'b0;
      for (waited = 0; waited < 500 && rsp_idx < exp_q.size(); waited++)
         @(negedge clk);
      if (rsp_idx < exp_q.size())
         stop_on_timeout("pending responses did not leave within 500 cycles");
   endtask

   function automatic exec_req_t random_req(input logic branch);
      exec_req_t req;
      req.tag       = '0;
      req.pc        = word_t'($urandom);
      req.pred_npc  = word_t'($urandom);
      req.a         = word_t'($urandom);
      req.b         = word_t'($urandom);
      req.imm       = word_t'($urandom);
      req.alu_op    = alu_op_t'(4'($urandom_range(11, 0)));
      req.src_b     = src_b_t'(2'($urandom));
      req.swap      = 1'($urandom);
      req.is_branch = branch;
      return req;
   endfunction

   // branch compare predicted right about half the time
   function automatic exec_req_t branch_req();
      exec_req_t req;
      exec_rsp_t rsp;
      req        = random_req(1'b1);
      req.alu_op = alu_op_t'(4'(8 + $urandom_range(3, 0)));
      // equal operands so beq also takes
      if (1'($urandom)) begin
         req.src_b = src_b_reg;
         req.b     = req.a;
      end
      rsp = expected_rsp(req);
      if (1'($urandom))
         req.pred_npc = rsp.resolved_pc;
      else
         req.pred_npc = rsp.resolved_pc ^ word_t'($urandom_range(65535, 1));
      return req;
   endfunction

   ////////////////////
   // sequence
   ////////////////////

   // ends the run once a wait has timed out
   initial begin
      wait (timed_out);
      finish_run();
   end

   initial begin
      exec_req_t req;
      void'($urandom(29));
      reset_n = 1'b0;
      i_valid = 1'b0;
      i_req   = '0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      reset_n = 1'b1;
      repeat (3) @(posedge clk);
      end_test();

      // every op, every operand b source, both orders
      begin_test("alu_results", 1'b0, 1'b0);
      for (int op = 0; op < 12; op++) begin
         for (int sb = 0; sb < 4; sb++) begin
            for (int sw = 0; sw < 2; sw++) begin
               req        = random_req(1'b0);
               req.alu_op = alu_op_t'(4'(op));
               req.src_b  = src_b_t'(2'(sb));
               req.swap   = 1'(sw);
               send(req);
            end
         end
      end
      drain();
      end_test();

      // every fourth item is not a branch
      begin_test("branch_resolution", 1'b0, 1'b0);
      for (int n = 0; n < 80; n++) begin
         if (n % 4 == 3)
            send(random_req(1'b0));
         else
            send(branch_req());
      end
      drain();
      end_test();

      begin_test("counters", 1'b1, 1'b0);
      for (int n = 0; n < 100; n++) begin
         if (1'($urandom))
            send(branch_req());
         else
            send(random_req(1'b0));
      end
      drain();
      count_check: assert (o_num_branch == seen_branch && o_num_branch_miss == seen_miss)
         else begin
            $display("error %s: expected %0d/%0d actual %0d/%0d", test_name,
                     seen_branch, seen_miss, o_num_branch, o_num_branch_miss);
            cnt_errors++;
         end
      end_test();

      // order and holding checked by the scoreboard and stall_hold
      begin_test("back_pressure", 1'b1, 1'b0);
      for (int n = 0; n < 120; n++)
         send(random_req(1'($urandom)));
      drain();
      end_test();

      begin_test("throughput", 1'b0, 1'b1);
      for (int n = 0; n < 40; n++)
         send(random_req(1'($urandom)));
      drain();
      end_test();
      lat_check = 1'b0;

      finish_run();
   end

endmodule

`default_nettype wire

//--- src/exec_stage.sv
`timescale 1ns/100ps
`default_nettype none

module exec_stage (
   input  wire                      clk,
   input  wire                      reset_n,
   // request side
   input  wire                      i_valid,
   output logic                     o_ready,
   input  wire exec_pkg::exec_req_t i_req,
   // response side
   output logic                     o_valid,
   input  wire                      i_ready,
   output exec_pkg::exec_rsp_t      o_rsp,
   // statistics
   output exec_pkg::word_t          o_num_branch,
   output exec_pkg::word_t          o_num_branch_miss
);
   import exec_pkg::*;

   // accept strobe from the flow control
   logic          load;
   // stage 1 halves
   alu_stage_t    alu_stage;
   target_stage_t target_stage;

   ////////////////////
   // stage 1
   ////////////////////

   // result path
   exec_alu u_exec_alu (
      .clk     (clk),
      .reset_n (reset_n),
      .i_load  (load),
      .i_req   (i_req),
      .o_alu   (alu_stage)
   );

   // address path alongside the alu
   branch_target_unit u_branch_target_unit (
      .clk      (clk),
      .reset_n  (reset_n),
      .i_load   (load),
      .i_req    (i_req),
      .o_target (target_stage)
   );

   ////////////////////
   // output stage
   ////////////////////

   // owns all handshakes and the counters
   branch_resolve u_branch_resolve (
      .clk               (clk),
      .reset_n           (reset_n),
      .i_valid           (i_valid),
      .o_ready           (o_ready),
      .o_load            (load),
      .i_alu             (alu_stage),
      .i_target          (target_stage),
      .o_valid           (o_valid),
      .i_ready           (i_ready),
      .o_rsp             (o_rsp),
      .o_num_branch      (o_num_branch),
      .o_num_branch_miss (o_num_branch_miss)
   );

endmodule

`default_nettype wire

//--- src/branch_resolve.sv
`timescale 1ns/100ps
`default_nettype none

module branch_resolve (
   input  wire                     clk,
   input  wire                     reset_n,
   // input side
   input  wire                     i_valid,
   output logic                    o_ready,
   output logic                    o_load,
   // stage 1 data
   input  wire exec_pkg::alu_stage_t    i_alu,
   input  wire exec_pkg::target_stage_t i_target,
   // output side
   output logic                    o_valid,
   input  wire                     i_ready,
   output exec_pkg::exec_rsp_t     o_rsp,
   // statistics
   output exec_pkg::word_t         o_num_branch,
   output exec_pkg::word_t         o_num_branch_miss
);
   import exec_pkg::*;

   // stage 1 holds an item
   logic  s1_valid;
   // stage 1 moves into the output register
   logic  advance;
   // output handshake
   logic  drain;

   // combined result of stage 1
   logic  taken;
   logic  miss;
   word_t resolved_pc;

   ////////////////////
   // flow control
   ////////////////////

   assign drain   = o_valid & i_ready;
   // output register empty or emptying this cycle
   assign advance = s1_valid & (~o_valid | i_ready);
   assign o_ready = ~s1_valid | advance;
   assign o_load  = i_valid & o_ready;

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         s1_valid <= 1'b0;
         o_valid  <= 1'b0;
      end
      else begin
         // new item overrides the leaving one
         if (o_load)
            s1_valid <= 1'b1;
         else if (advance)
            s1_valid <= 1'b0;
         if (advance)
            o_valid <= 1'b1;
         else if (drain)
            o_valid <= 1'b0;
      end
   end

   ////////////////////
   // resolve
   ////////////////////

   // nonzero alu result means the condition held
   assign taken       = i_target.is_branch & (i_alu.result != '0);
   assign resolved_pc = taken ? i_target.taken_target : i_target.fallthrough;
   assign miss        = i_target.is_branch & (resolved_pc != i_target.pred_npc);

   // output register
   always_ff @(posedge clk) begin
      if (advance) begin
         o_rsp.tag         <= i_alu.tag;
         o_rsp.result      <= i_alu.result;
         o_rsp.is_branch   <= i_target.is_branch;
         o_rsp.taken       <= taken;
         o_rsp.miss        <= miss;
         o_rsp.resolved_pc <= resolved_pc;
      end
   end

   // counted only once the item has left
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         o_num_branch      <= '0;
         o_num_branch_miss <= '0;
      end
      else if (drain) begin
         if (o_rsp.is_branch)
            o_num_branch <= o_num_branch + word_one;
         if (o_rsp.miss)
            o_num_branch_miss <= o_num_branch_miss + word_one;
      end
   end

   ////////////////////
   // checks
   ////////////////////

   // stalled output holds its item
   a_rsp_stable : assert property (@(posedge clk) disable iff (!reset_n)
      (o_valid && !i_ready) |=> (o_valid && $stable(o_rsp)));

   // both halves of stage 1 loaded from the same item
   a_tag_match : assert property (@(posedge clk) disable iff (!reset_n)
      s1_valid |-> (i_alu.tag == i_target.tag));

   // every miss is also a branch
   a_miss_le_branch : assert property (@(posedge clk) disable iff (!reset_n)
      o_num_branch_miss <= o_num_branch);

endmodule

`default_nettype wire

//--- src/branch_target_unit.sv
`timescale 1ns/100ps
`default_nettype none

module branch_target_unit (
   input  wire                     clk,
   input  wire                     reset_n,
   input  wire                     i_load,
   input  wire exec_pkg::exec_req_t i_req,
   output exec_pkg::target_stage_t o_target
);
   import exec_pkg::*;

   // both candidates computed before the outcome is known
   word_t fallthrough;
   word_t taken_target;

   ////////////////////
   // address adders
   ////////////////////

   // pc + 1
   assign fallthrough = i_req.pc + word_one;

   // relative to the next instruction
   assign taken_target = fallthrough + i_req.imm;

   // stage 1 register
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         o_target.tag       <= '0;
         o_target.is_branch <= 1'b0;
      end
      else if (i_load) begin
         o_target.tag          <= i_req.tag;
         o_target.is_branch    <= i_req.is_branch;
         o_target.taken_target <= taken_target;
         o_target.fallthrough  <= fallthrough;
         // carried along for the miss check
         o_target.pred_npc     <= i_req.pred_npc;
      end
   end

endmodule

`default_nettype wire

//--- src/exec_alu.sv
`timescale 1ns/100ps
`default_nettype none

module exec_alu (
   input  wire                  clk,
   input  wire                  reset_n,
   input  wire                  i_load,
   input  wire exec_pkg::exec_req_t i_req,
   output exec_pkg::alu_stage_t o_alu
);
   import exec_pkg::*;

   // operand b before swap
   word_t opnd_b_sel;
   // operands after swap
   word_t opnd_1;
   word_t opnd_2;
   word_t alu_result;

   ////////////////////
   // operand select
   ////////////////////

   // operand a is always the register value
   always_comb begin
      case (i_req.src_b)
         src_b_reg:  opnd_b_sel = i_req.b;
         src_b_imm:  opnd_b_sel = i_req.imm;
         src_b_one:  opnd_b_sel = word_one;
         src_b_zero: opnd_b_sel = '0;
      endcase
   end

   // swap for reversed operand order
   assign opnd_1 = i_req.swap ? opnd_b_sel : i_req.a;
   assign opnd_2 = i_req.swap ? i_req.a : opnd_b_sel;

   ////////////////////
   // alu
   ////////////////////

   always_comb begin
      case (i_req.alu_op)
         alu_add: alu_result = opnd_1 + opnd_2;
         alu_sub: alu_result = opnd_1 - opnd_2;
         alu_and: alu_result = opnd_1 & opnd_2;
         alu_or:  alu_result = opnd_1 | opnd_2;
         alu_xor: alu_result = opnd_1 ^ opnd_2;
         // unary ops use operand 1 only
         alu_not: alu_result = ~opnd_1;
         alu_shl: alu_result = opnd_1 << 1;
         alu_sra: alu_result = word_t'($signed(opnd_1) >>> 1);
         // branch checks feed the taken decision
         alu_bne: alu_result = word_t'(opnd_1 != opnd_2);
         alu_beq: alu_result = word_t'(opnd_1 == opnd_2);
         alu_bgz: alu_result = word_t'($signed(opnd_1) > 0);
         alu_blz: alu_result = word_t'($signed(opnd_1) < 0);
         default: alu_result = '0;
      endcase
   end

   // stage 1 register
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         o_alu.tag <= '0;
      end
      else if (i_load) begin
         o_alu.tag    <= i_req.tag;
         o_alu.result <= alu_result;
      end
   end

   // decoder upstream must only send codes from the table
   a_alu_op_defined : assert property (@(posedge clk) disable iff (!reset_n)
      i_load |-> (i_req.alu_op inside {[alu_add:alu_blz]}))
      else $error("exec_alu: undefined alu_op %0h", i_req.alu_op);

endmodule

`default_nettype wire

//--- src/exec_pkg.sv
`default_nettype none

package exec_pkg;

   ////////////////////
   // sizes
   ////////////////////

   // data and address width
   localparam int word_width = 16;

   // item identifier width
   localparam int tag_width = 4;

   typedef logic [word_width-1:0] word_t;
   typedef logic [tag_width-1:0]  tag_t;

   // constant one in word width
   // used for pc increment and the one operand
   localparam word_t word_one = word_t'(1);

   ////////////////////
   // encodings
   ////////////////////

   // alu operations
   // compare ops give 1 or 0 in bit zero
   typedef enum logic [3:0] {
      alu_add = 4'd0,
      alu_sub = 4'd1,
      alu_and = 4'd2,
      alu_or  = 4'd3,
      alu_xor = 4'd4,
      alu_not = 4'd5,
      alu_shl = 4'd6,
      alu_sra = 4'd7,
      alu_bne = 4'd8,
      alu_beq = 4'd9,
      alu_bgz = 4'd10,
      alu_blz = 4'd11
   } alu_op_t;

   // operand b source
   typedef enum logic [1:0] {
      src_b_reg  = 2'd0,
      src_b_imm  = 2'd1,
      src_b_one  = 2'd2,
      src_b_zero = 2'd3
   } src_b_t;

   ////////////////////
   // items
   ////////////////////

   // decoded item entering execute
   typedef struct packed {
      tag_t    tag;
      word_t   pc;
      // predicted next pc from fetch
      word_t   pred_npc;
      word_t   a;
      word_t   b;
      // already sign extended
      word_t   imm;
      alu_op_t alu_op;
      src_b_t  src_b;
      logic    swap;
      logic    is_branch;
   } exec_req_t;

   // resolved item leaving execute
   typedef struct packed {
      tag_t  tag;
      word_t result;
      logic  is_branch;
      logic  taken;
      logic  miss;
      word_t resolved_pc;
   } exec_rsp_t;

   // stage 1 alu side
   typedef struct packed {
      tag_t  tag;
      word_t result;
   } alu_stage_t;

   // stage 1 address side
   typedef struct packed {
      tag_t  tag;
      logic  is_branch;
      word_t taken_target;
      word_t fallthrough;
      word_t pred_npc;
   } target_stage_t;

endpackage

`default_nettype wire
